//--- source/prefetch_cfg.svh
`ifndef PREFETCH_CFG_SVH
`define PREFETCH_CFG_SVH

// fetch fifo entries, one word each
// the fill threshold needs at least 3
`define PF_FIFO_DEPTH 4

// instruction address width
`define PF_ADDR_W 32

// width of a fetched memory word
`define PF_DATA_W 32

`endif

//--- source/prefetch_pkg.sv
`include "prefetch_cfg.svh"

package prefetch_pkg;

  // byte address of an instruction, may sit on a halfword
  typedef logic [`PF_ADDR_W-1:0] addr_t;

  // one word as returned by instruction memory
  typedef logic [`PF_DATA_W-1:0] word_t;

  // one fifo slot, the word and the address it came from
  typedef struct packed {
    addr_t addr;
    word_t rdata;
  } fifo_entry_t;

  // memory request fsm
  // WAIT_ABORTED drops the rvalid of a request that a branch overtook
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    WAIT_GNT     = 2'd1,
    WAIT_RVALID  = 2'd2,
    WAIT_ABORTED = 2'd3
  } fetch_state_e;

endpackage

//--- source/fifo_head_if.sv
`include "prefetch_cfg.svh"

interface fifo_head_if;

  // head_valid and next_valid only reflect stored slots
  // an arriving word is folded in by the aligner
  logic                      head_valid;
  // head entry, bypasses the arriving word when slot 0 is empty
  prefetch_pkg::fifo_entry_t head;
  logic                      next_valid;
  // stored word behind the head, the upper half of a spanning instr
  prefetch_pkg::word_t       next_rdata;

  // drop the head word and shift the rest down
  logic                      pop_word;
  // move the head address to the upper halfword
  logic                      step_half;

  modport fifo (
    output head_valid,
    output head,
    output next_valid,
    output next_rdata,
    input  pop_word,
    input  step_half
  );

  modport aligner (
    input  head_valid,
    input  head,
    input  next_valid,
    input  next_rdata,
    output pop_word,
    output step_half
  );

endinterface

//--- source/fetch_fifo.sv
`include "prefetch_cfg.svh"

module fetch_fifo (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_valid_i,
  input  prefetch_pkg::addr_t push_addr_i,
  input  prefetch_pkg::word_t push_rdata_i,
  input  logic                flush_i,
  output logic                ready_o,
  fifo_head_if.fifo           head
);

  // slot 0 is the head, valid bits are always packed from slot 0 up
  prefetch_pkg::fifo_entry_t entries_q [`PF_FIFO_DEPTH];
  prefetch_pkg::fifo_entry_t entries_d [`PF_FIFO_DEPTH];
  logic [`PF_FIFO_DEPTH-1:0] valid_q;
  logic [`PF_FIFO_DEPTH-1:0] valid_d;

  prefetch_pkg::fifo_entry_t head_entry;
  logic                      placed;
  logic                      cross_word;

  //////////////////////////////////////////////////
  // head side
  //////////////////////////////////////////////////

  // empty fifo: the word from memory goes straight out
  always_comb begin
    if (valid_q[0]) begin
      head_entry = entries_q[0];
    end else begin
      head_entry.addr  = push_addr_i;
      head_entry.rdata = push_rdata_i;
    end
  end

  assign head.head_valid = valid_q[0];
  assign head.head       = head_entry;
  assign head.next_valid = valid_q[1];
  assign head.next_rdata = entries_q[1].rdata;

  // 32-bit instr on the upper half, it ends inside the next word
  assign cross_word = head_entry.addr[1] & (head_entry.rdata[17:16] == 2'b11);

  //////////////////////////////////////////////////
  // fill level
  //////////////////////////////////////////////////

  // stop new requests one slot early, one word may still be in flight
  assign ready_o = ~valid_q[`PF_FIFO_DEPTH-2];

  //////////////////////////////////////////////////
  // push and shift
  //////////////////////////////////////////////////

  always_comb begin
    placed    = 1'b0;
    entries_d = entries_q;
    valid_d   = valid_q;

    // push into the lowest free slot
    if (push_valid_i) begin
      for (int i = 0; i < `PF_FIFO_DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          entries_d[i].addr  = push_addr_i;
          entries_d[i].rdata = push_rdata_i;
          valid_d[i]         = 1'b1;
          placed             = 1'b1;
        end
      end
    end

    // pop after push so a bypassed word can be consumed at once
    if (head.pop_word) begin
      for (int i = 0; i < `PF_FIFO_DEPTH-1; i++) begin
        entries_d[i] = entries_d[i+1];
        valid_d[i]   = valid_d[i+1];
      end
      valid_d[`PF_FIFO_DEPTH-1] = 1'b0;
      // new head starts on its upper half when the old instr spilled over
      entries_d[0].addr = {entries_d[0].addr[`PF_ADDR_W-1:2], cross_word, 1'b0};
    end else if (head.step_half) begin
      entries_d[0].addr[1] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  // flush empties the fifo for the next cycle, a push in that cycle is lost
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    entries_q <= entries_d;
  end

endmodule

//--- source/instr_aligner.sv
`include "prefetch_cfg.svh"

module instr_aligner (
  fifo_head_if.aligner        head,
  input  logic                ready_i,
  input  logic                push_valid_i,
  input  prefetch_pkg::word_t push_rdata_i,
  output logic                valid_o,
  output prefetch_pkg::word_t rdata_o,
  output prefetch_pkg::addr_t addr_o
);

  prefetch_pkg::word_t cur_word;
  prefetch_pkg::word_t next_word;
  logic                head_ok;
  logic                next_ok;
  logic                unaligned;
  logic                lo_compressed;
  logic                hi_compressed;
  logic                take;

  //////////////////////////////////////////////////
  // word availability
  //////////////////////////////////////////////////

  assign cur_word  = head.head.rdata;
  assign unaligned = head.head.addr[1];

  // head is stored or arriving right now
  assign head_ok = head.head_valid | push_valid_i;

  // next word is stored, or arriving behind a stored head
  assign next_ok   = head.next_valid | (head.head_valid & push_valid_i);
  assign next_word = head.next_valid ? head.next_rdata : push_rdata_i;

  // rvc rule: both low bits set means a 32-bit instr
  assign lo_compressed = cur_word[1:0] != 2'b11;
  assign hi_compressed = cur_word[17:16] != 2'b11;

  //////////////////////////////////////////////////
  // instruction select
  //////////////////////////////////////////////////

  // compressed instrs come out zero extended
  always_comb begin
    if (unaligned) begin
      if (hi_compressed) begin
        rdata_o = {16'h0000, cur_word[31:16]};
        valid_o = head_ok;
      end else begin
        // spanning instr, upper half lives in the next word
        rdata_o = {next_word[15:0], cur_word[31:16]};
        valid_o = next_ok;
      end
    end else begin
      if (lo_compressed) begin
        rdata_o = {16'h0000, cur_word[15:0]};
      end else begin
        rdata_o = cur_word;
      end
      valid_o = head_ok;
    end
  end

  assign addr_o = head.head.addr;

  //////////////////////////////////////////////////
  // fifo step
  //////////////////////////////////////////////////

  assign take = valid_o & ready_i;

  // only an aligned compressed instr leaves the word in place
  assign head.step_half = take & ~unaligned & lo_compressed;
  assign head.pop_word  = take & (unaligned | ~lo_compressed);

endmodule

//--- source/fetch_ctrl.sv
`include "prefetch_cfg.svh"

module fetch_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t branch_addr_i,
  input  logic                fifo_ready_i,
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output prefetch_pkg::addr_t instr_addr_o,
  input  logic                instr_rvalid_i,
  output logic                push_valid_o,
  output prefetch_pkg::addr_t push_addr_o,
  output logic                busy_o
);

  prefetch_pkg::fetch_state_e state_q;
  prefetch_pkg::fetch_state_e state_d;

  // address of the last accepted request
  prefetch_pkg::addr_t addr_q;
  prefetch_pkg::addr_t fetch_addr;
  logic                addr_valid;

  // next sequential word, a branch target may be a halfword
  assign fetch_addr = {addr_q[`PF_ADDR_W-1:2], 2'b00} + `PF_ADDR_W'd4;

  // rdata always belongs to the registered request
  assign push_addr_o = addr_q;

  assign busy_o = (state_q != prefetch_pkg::IDLE) || instr_req_o;

  //////////////////////////////////////////////////
  // request fsm
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = branch_i ? branch_addr_i : fetch_addr;
    push_valid_o = 1'b0;
    addr_valid   = 1'b0;

    case (state_q)
      // nothing outstanding
      prefetch_pkg::IDLE: begin
        if (req_i && (fifo_ready_i || branch_i)) begin
          instr_req_o = 1'b1;
          addr_valid  = 1'b1;
          state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
        end
      end

      // hold req and address until granted, a branch retargets
      prefetch_pkg::WAIT_GNT: begin
        instr_req_o = 1'b1;
        if (branch_i) begin
          addr_valid = 1'b1;
        end else begin
          instr_addr_o = addr_q;
        end
        if (instr_gnt_i) begin
          state_d = prefetch_pkg::WAIT_RVALID;
        end
      end

      // granted, data still on its way
      prefetch_pkg::WAIT_RVALID: begin
        if (req_i && (fifo_ready_i || branch_i)) begin
          if (instr_rvalid_i) begin
            // back to back, the next request goes out with the data
            instr_req_o  = 1'b1;
            push_valid_o = ~branch_i;
            addr_valid   = 1'b1;
            state_d      = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
          end else if (branch_i) begin
            // remember the target, the old rvalid is still due
            addr_valid = 1'b1;
            state_d    = prefetch_pkg::WAIT_ABORTED;
          end
        end else if (instr_rvalid_i) begin
          push_valid_o = ~branch_i;
          state_d      = prefetch_pkg::IDLE;
        end
      end

      // stale word pending, addr_q already holds the new target
      prefetch_pkg::WAIT_ABORTED: begin
        if (branch_i) begin
          addr_valid = 1'b1;
        end else begin
          instr_addr_o = addr_q;
        end
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
        end
      end

      default: begin
        state_d = prefetch_pkg::IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= prefetch_pkg::IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_valid) begin
        addr_q <= instr_addr_o;
      end
    end
  end

endmodule

//--- source/prefetch_buffer.sv
`include "prefetch_cfg.svh"

module prefetch_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t addr_i,
  input  logic                ready_i,
  output logic                valid_o,
  output prefetch_pkg::word_t rdata_o,
  output prefetch_pkg::addr_t addr_o,
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output prefetch_pkg::addr_t instr_addr_o,
  input  prefetch_pkg::word_t instr_rdata_i,
  input  logic                instr_rvalid_i,
  output logic                busy_o
);

  // fetch controller to fifo
  logic                push_valid;
  prefetch_pkg::addr_t push_addr;
  logic                fifo_ready;

  // fifo head to aligner
  fifo_head_if head_if ();

  //////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////

  fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (addr_i),
    .fifo_ready_i   (fifo_ready),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .push_valid_o   (push_valid),
    .push_addr_o    (push_addr),
    .busy_o         (busy_o)
  );

  //////////////////////////////////////////////////
  // storage and output side
  //////////////////////////////////////////////////

  // a branch flushes the fifo directly
  fetch_fifo u_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid_i (push_valid),
    .push_addr_i  (push_addr),
    .push_rdata_i (instr_rdata_i),
    .flush_i      (branch_i),
    .ready_o      (fifo_ready),
    .head         (head_if.fifo)
  );

  instr_aligner u_instr_aligner (
    .head         (head_if.aligner),
    .ready_i      (ready_i),
    .push_valid_i (push_valid),
    .push_rdata_i (instr_rdata_i),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .addr_o       (addr_o)
  );

endmodule

//--- tests/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release a little after the edge, like the other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

//--- tests/prefetch_checker.sv
`include "prefetch_cfg.svh"

module prefetch_checker (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      branch_i,
  input logic                      instr_req_o,
  input logic                      instr_gnt_i,
  input prefetch_pkg::addr_t       instr_addr_o,
  input logic                      busy_o,
  input logic                      valid_o,
  input logic                      push_valid_i,
  input logic [`PF_FIFO_DEPTH-1:0] fifo_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // fifo and memory bus rules
  //////////////////////////////////////////////////

  // a word arriving into a full fifo would be dropped
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid_i |-> !(&fifo_valid_i))
    else $error("push into a full fetch fifo");

  // request and address held until the grant, a branch may retarget
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && (branch_i || $stable(instr_addr_o))))
    else $error("instr_addr_o changed while waiting for grant");

  // a granted word is still due, so the fsm cannot be idle
  a_busy_req: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && instr_gnt_i) |=> busy_o)
    else $error("busy_o low while a granted fetch is outstanding");

  // first cycle out of reset
  a_valid_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !valid_o)
    else $error("valid_o high right after reset");

endmodule

bind prefetch_buffer prefetch_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .branch_i     (branch_i),
  .instr_req_o  (instr_req_o),
  .instr_gnt_i  (instr_gnt_i),
  .instr_addr_o (instr_addr_o),
  .busy_o       (busy_o),
  .valid_o      (valid_o),
  .push_valid_i (push_valid),
  .fifo_valid_i (u_fetch_fifo.valid_q)
);

//--- tests/prefetch_tb.sv
module prefetch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          RESET_CYCLES = 8;
  localparam int          IDLE_CYCLES  = 5;
  localparam logic [31:0] IMG_BASE     = 32'h0000_1000;
  // below this address every word is one 32-bit instr
  localparam logic [31:0] MIXED_BASE   = 32'h0000_1400;

  typedef struct {
    string       name;
    logic [31:0] target;
    int          count;
    bit          rand_ready;
  } test_row_t;

  logic                clk;
  logic                rst_n;
  logic                req_i;
  logic                branch_i;
  prefetch_pkg::addr_t addr_i;
  logic                ready_i;
  logic                valid_o;
  prefetch_pkg::word_t rdata_o;
  prefetch_pkg::addr_t addr_o;
  logic                instr_req_o;
  logic                instr_gnt_i;
  prefetch_pkg::addr_t instr_addr_o;
  prefetch_pkg::word_t instr_rdata_i;
  logic                instr_rvalid_i;
  logic                busy_o;

  // 4 KB instruction image, word i sits at IMG_BASE + 4*i
  logic [31:0] image [1024];
  test_row_t   rows[$];
  int          error_count;
  int          cycle_count;
  int          cycle_limit;

  // memory model state
  logic        outstanding;
  logic [31:0] mem_addr;
  int          rv_wait;
  int          gnt_wait;

  tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  prefetch_buffer dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  //////////////////////////////////////////////////
  // image and reference walk
  //////////////////////////////////////////////////

  // halfword content from a hash of the full address
  function automatic logic [15:0] half_rule(logic [31:0] ha);
    logic [31:0] h;
    h = (ha ^ 32'h5bd1_e995) * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    if (ha < MIXED_BASE) begin
      return ha[1] ? h[15:0] : {h[15:2], 2'b11};
    end
    // mixed region, about half start a 32-bit instr
    return h[2] ? {h[15:2], 2'b11} : {h[15:2], h[0], 1'b0};
  endfunction

  function automatic logic [15:0] image_half(logic [31:0] ha);
    logic [31:0] w;
    w = image[ha[11:2]];
    return ha[1] ? w[31:16] : w[15:0];
  endfunction

  // rvc length rule, low bits 11 means 32 bits
  function automatic logic [31:0] expected_instr(logic [31:0] ha);
    logic [15:0] lo;
    lo = image_half(ha);
    if (lo[1:0] == 2'b11) begin
      return {image_half(ha + 32'd2), lo};
    end
    return {16'h0000, lo};
  endfunction

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////

  task automatic stop_failed();
    $display("Finished with errors");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] got);
    assert (got === exp) else begin
      error_count++;
      $display("** Error: test %s, %s expected %h actual %h", test, what, exp, got);
      stop_failed();
    end
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  // sample the bus at the edge, drive the response 2 ns later
  always @(posedge clk) begin
    if (rst_n) begin
      if (instr_rvalid_i) begin
        outstanding = 1'b0;
      end
      if (instr_req_o && instr_gnt_i) begin
        mem_addr    = instr_addr_o;
        outstanding = 1'b1;
        rv_wait     = 1 + int'($urandom % 2);
        gnt_wait    = int'($urandom % 3);
        assert (mem_addr >= IMG_BASE && mem_addr < IMG_BASE + 32'h1000) else begin
          $display("memory request at %h is outside the instruction image", mem_addr);
          stop_failed();
        end
      end else if (gnt_wait > 0) begin
        gnt_wait--;
      end
    end
    #2;
    instr_rvalid_i = 1'b0;
    instr_gnt_i    = 1'b0;
    if (outstanding) begin
      rv_wait--;
      if (rv_wait == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = image[mem_addr[11:2]];
      end
    end
    // one outstanding at most, a grant may overlap the rvalid
    if (rst_n && gnt_wait == 0 && (!outstanding || instr_rvalid_i)) begin
      instr_gnt_i = 1'b1;
    end
  end

  // timeout
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout, test did not finish within %0d cycles", cycle_limit);
      stop_failed();
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic add_row(string name, logic [31:0] target, int count, bit rand_ready);
    test_row_t r;
    r.name       = name;
    r.target     = target;
    r.count      = count;
    r.rand_ready = rand_ready;
    rows.push_back(r);
  endtask

  function automatic logic pick_ready(bit rand_ready);
    return rand_ready ? (($urandom & 32'd1) != 32'd0) : 1'b1;
  endfunction

  // called 2 ns after an edge, returns 2 ns after an edge
  task automatic run_test(test_row_t r);
    logic [31:0] exp_addr;
    logic [31:0] exp_instr;
    int          got;
    exp_addr = r.target;
    got      = 0;
    // branch cycle, ready held low
    req_i    = 1'b1;
    branch_i = 1'b1;
    addr_i   = r.target;
    ready_i  = 1'b0;
    @(posedge clk);
    #2;
    branch_i = 1'b0;
    ready_i  = pick_ready(r.rand_ready);
    while (got < r.count) begin
      @(posedge clk);
      if (valid_o && ready_i) begin
        exp_instr = expected_instr(exp_addr);
        check_value(r.name, "addr", exp_addr, addr_o);
        check_value(r.name, "instr", exp_instr, rdata_o);
        exp_addr = exp_addr + ((exp_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
        got++;
      end
      #2;
      ready_i = (got < r.count) ? pick_ready(r.rand_ready) : 1'b0;
    end
  endtask

  initial begin
    int total;
    req_i          = 1'b0;
    branch_i       = 1'b0;
    addr_i         = '0;
    ready_i        = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rdata_i  = '0;
    instr_rvalid_i = 1'b0;
    outstanding    = 1'b0;
    mem_addr       = '0;
    rv_wait        = 0;
    gnt_wait       = 0;
    error_count    = 0;
    cycle_count    = 0;
    void'($urandom(32'hb159a4b6));

    for (int i = 0; i < 1024; i++) begin
      image[i] = {half_rule(IMG_BASE + 32'(4 * i) + 32'd2), half_rule(IMG_BASE + 32'(4 * i))};
    end

    // name, target, instr count, random ready
    add_row("aligned_32", 32'h0000_1000, 20, 1'b0);
    add_row("mixed", 32'h0000_1400, 30, 1'b0);
    add_row("unaligned_branch", 32'h0000_1602, 20, 1'b0);
    add_row("random_ready", 32'h0000_1800, 60, 1'b1);
    add_row("random_unaligned", 32'h0000_1a06, 40, 1'b1);

    total = 0;
    foreach (rows[i]) begin
      total += rows[i].count;
    end
    cycle_limit = total * 12 + RESET_CYCLES + IDLE_CYCLES + rows.size();

    wait (rst_n === 1'b1);
    // idle after reset, nothing may move with req_i low
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      check_value("idle", "valid_o", 32'd0, 32'(valid_o));
      check_value("idle", "instr_req_o", 32'd0, 32'(instr_req_o));
      check_value("idle", "busy_o", 32'd0, 32'(busy_o));
    end
    #2;

    // back to back, so later branches hit a pending fetch
    foreach (rows[i]) begin
      run_test(rows[i]);
    end

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- prefetch.f
+incdir+source
source/prefetch_pkg.sv
source/fifo_head_if.sv
source/fetch_fifo.sv
source/instr_aligner.sv
source/fetch_ctrl.sv
source/prefetch_buffer.sv
tests/tb_clock_gen.sv
tests/prefetch_checker.sv
tests/prefetch_tb.sv

//--- Makefile
# verilator build and run for the prefetch buffer testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f prefetch.f --top-module prefetch_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vprefetch_tb | tee run.log
	grep -q "Finished with no errors" run.log

clean:
	rm -rf $(OBJ_DIR) run.log
